//--- common/flash_pkg.sv
// SPI NOR flash side of the loader: read command and address layout
package flash_pkg;

    localparam logic [7:0] read_opcode = 8'h03; // plain single-bit read
    localparam int         cmd_bits    = 32;    // opcode + 24 bit address
    localparam int         page_w      = 12;    // page field inside the address

    typedef logic [cmd_bits-1:0] flash_cmd_t;   // shifted out msb first
    typedef logic [2:0]          img_t;         // image select

    localparam logic [page_w-1:0] boot_page = 12'h805; // bootloader + map start here

    // address = 00 iii pppppppppppp 0000000
    // one page field step is 128 bytes of flash
    function automatic flash_cmd_t build_cmd(
        input img_t              img,
        input logic [page_w-1:0] page
    );
        return {read_opcode, 2'b00, img, page, 7'b000_0000};
    endfunction

endpackage

//--- common/bubble_pkg.sv
// bubble output buffer and bad-loop map side of the loader
package bubble_pkg;

    typedef logic [11:0] page_t;      // page number from the requester
    typedef logic [14:0] buf_addr_t;  // bubble out buffer write address
    typedef logic [11:0] map_idx_t;   // loop map table index
    typedef logic [11:0] bit_cnt_t;   // bit counter inside one region

    localparam int map_depth = 4096;  // one entry per loop position

    // buffer layout
    localparam buf_addr_t boot_base = 15'd4106;   // bootloader region
    localparam buf_addr_t page_base = 15'd14336;  // page region

    // region lengths in bits
    // map region carries 1168 map bits and 32 trailing bits, all stored
    localparam bit_cnt_t map_bits  = 12'd1200;
    localparam bit_cnt_t sync_bits = 12'd6;       // good sync positions before data

endpackage

//--- common/flash_if.sv
`timescale 1ns/1ps

// sequencer <-> spi reader
interface flash_if;

    logic                  cmd_start;  // drop cs, start command
    flash_pkg::flash_cmd_t cmd;        // opcode + address
    logic                  bit_req;    // fetch one data bit
    logic                  cs_release; // raise cs, end of load
    logic                  cmd_done;   // all command bits clocked out
    logic                  bit_valid;  // bit_data is fresh
    logic                  bit_data;   // sampled miso

    modport seq (
        output cmd_start, cmd, bit_req, cs_release,
        input  cmd_done, bit_valid, bit_data
    );

    modport spi (
        input  cmd_start, cmd, bit_req, cs_release,
        output cmd_done, bit_valid, bit_data
    );

endinterface

//--- common/map_if.sv
`timescale 1ns/1ps

// sequencer <-> loop map table
interface map_if;

    logic rewind;   // index back to 0
    logic wr;       // store wr_data, advance index
    logic wr_data;  // map bit, 1 = good loop
    logic rd;       // read plain index, advance
    logic rd_data;  // valid the cycle after rd

    modport seq (output rewind, wr, wr_data, rd, input rd_data);

    modport lut (input rewind, wr, wr_data, rd, output rd_data);

endinterface

//--- flash/flash_reader.sv
`timescale 1ns/1ps

// spi master for the nor flash, cpol=1
// command goes out msb first, data comes back one bit per request
module flash_reader (
    input  logic MCLK,
    input  logic rst_n,
    flash_if.spi spi,
    output logic flash_cs_n,
    output logic flash_sck,
    output logic flash_mosi,
    input  logic flash_miso
);

    localparam int cnt_w = $clog2(flash_pkg::cmd_bits);

    logic [cnt_w-1:0]      bit_cnt;  // command bits already clocked in by the flash
    logic                  cmd_act;  // command shifting
    logic                  rd_act;   // sck low phase of a data bit
    flash_pkg::flash_cmd_t sh_reg;   // remaining command bits

    always_ff @(posedge MCLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            flash_cs_n    <= 1'b1;
            flash_sck     <= 1'b1;  // idle high
            flash_mosi    <= 1'b0;
            bit_cnt       <= '0;
            cmd_act       <= 1'b0;
            rd_act        <= 1'b0;
            spi.cmd_done  <= 1'b0;
            spi.bit_valid <= 1'b0;
        end
        else
        begin
            spi.cmd_done  <= 1'b0;
            spi.bit_valid <= 1'b0;
            if (spi.cmd_start)
            begin
                flash_cs_n <= 1'b0;
                flash_sck  <= 1'b0;               // first bit goes out right away
                flash_mosi <= spi.cmd[flash_pkg::cmd_bits-1];
                bit_cnt    <= '0;
                cmd_act    <= 1'b1;
            end
            else if (cmd_act)
            begin
                if (!flash_sck)
                begin
                    flash_sck <= 1'b1;            // flash latches mosi here
                    if (bit_cnt == cnt_w'(flash_pkg::cmd_bits - 1))
                    begin
                        cmd_act      <= 1'b0;
                        spi.cmd_done <= 1'b1;     // 64 cycles after cmd_start
                    end
                    else
                    begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                else
                begin
                    flash_sck  <= 1'b0;           // mosi changes with sck low
                    flash_mosi <= sh_reg[flash_pkg::cmd_bits-1];
                end
            end
            else if (spi.bit_req)
            begin
                flash_sck <= 1'b0;                // flash drives next bit on this fall
                rd_act    <= 1'b1;
            end
            else if (rd_act)
            begin
                flash_sck     <= 1'b1;            // miso sampled on this edge
                rd_act        <= 1'b0;
                spi.bit_valid <= 1'b1;
            end
            if (spi.cs_release)
            begin
                flash_cs_n <= 1'b1;
                flash_sck  <= 1'b1;
                cmd_act    <= 1'b0;
                rd_act     <= 1'b0;
            end
        end
    end

    // command shifter and read data
    always_ff @(posedge MCLK)
    begin
        if (spi.cmd_start)
            sh_reg <= spi.cmd << 1;               // msb already on mosi
        else if (cmd_act && flash_sck)
            sh_reg <= sh_reg << 1;
        if (rd_act)
            spi.bit_data <= flash_miso;
    end

endmodule

//--- hdl/loop_map_table.sv
`timescale 1ns/1ps

// bad-loop mask, 1 bit per loop position
// map bits arrive from flash in a nibble-swapped order, so the write side
// inverts the low nibble of the index and the read side walks it plainly
module loop_map_table (
    input  logic MCLK,
    input  logic rst_n,
    map_if.lut   tbl
);

    logic                mask [bubble_pkg::map_depth]; // 1 = good loop
    bubble_pkg::map_idx_t idx;                         // shared rd/wr index
    bubble_pkg::map_idx_t wr_idx;

    assign wr_idx = {idx[11:4], ~idx[3:0]};  // emulator loop ordering

    always_ff @(posedge MCLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            idx <= '0;
        end
        else if (tbl.rewind)
        begin
            idx <= '0;                       // new load starts at loop 0
        end
        else if (tbl.wr || tbl.rd)
        begin
            idx <= idx + 1'b1;               // wraps at map_depth
        end
    end

    always_ff @(posedge MCLK)
    begin
        if (tbl.wr)
            mask[wr_idx] <= tbl.wr_data;
        if (tbl.rd)
            tbl.rd_data <= mask[idx];        // 1 cycle latency
    end

endmodule

//--- hdl/load_sequencer.sv
`timescale 1ns/1ps

// access fsm: boot access = bootloader + map, page access = sync + masked page
module load_sequencer #(
    parameter int BOOT_BITS = 2656,
    parameter int PAGE_BITS = 1030
) (
    input  logic                  MCLK,
    input  logic                  rst_n,
    input  flash_pkg::img_t       img_num,
    input  bubble_pkg::page_t     page_num,
    input  logic                  acc_req,
    input  logic                  acc_page,
    flash_if.seq                  seq,
    map_if.seq                    map,
    output logic                  buf_wr_n,
    output bubble_pkg::buf_addr_t buf_addr,
    output logic                  buf_data
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_WAIT_REL,  // load done, wait for acc_req low
        S_CMD,
        S_BOOT,
        S_MAP,
        S_SYNC,
        S_PAGE
    } state_t;

    // steps of one buffer write
    typedef enum logic [2:0] {
        ST_REQ,      // ask flash for a bit
        ST_WAIT,     // wait bit_valid
        ST_MAPRD,    // read loop map
        ST_MAPCHK,   // map bit on rd_data
        ST_WR        // buf_wr_n low
    } step_t;

    state_t               state;
    step_t                step;
    bubble_pkg::bit_cnt_t cnt;       // good bits in current region
    logic                 page_acc;  // captured acc_page
    logic                 wr_go;     // start a buffer write
    logic                 wr_bit;
    logic                 good;      // this write counts toward the region
    logic                 last_bit;

    always_comb
    begin
        seq.bit_req = (state inside {S_BOOT, S_MAP, S_PAGE}) && (step == ST_REQ);
        map.rd      = (state inside {S_SYNC, S_PAGE}) && (step == ST_MAPRD);
        map.wr      = (state == S_MAP) && (step == ST_WAIT) && seq.bit_valid; // map copy
        map.wr_data = seq.bit_data;
        // bad loop in page data writes 0 here too, good one goes to flash first
        wr_go  = ((step == ST_WAIT) && seq.bit_valid) ||
                 ((step == ST_MAPCHK) && !((state == S_PAGE) && map.rd_data));
        wr_bit = (step == ST_WAIT) ? seq.bit_data : map.rd_data; // sync: good=1, bad=0
        good   = (step == ST_WAIT) || map.rd_data;
        case (state)
            S_BOOT:  last_bit = (cnt == bubble_pkg::bit_cnt_t'(BOOT_BITS));
            S_MAP:   last_bit = (cnt == bubble_pkg::map_bits);
            S_SYNC:  last_bit = (cnt == bubble_pkg::sync_bits);
            S_PAGE:  last_bit = (cnt == bubble_pkg::bit_cnt_t'(PAGE_BITS));
            default: last_bit = 1'b0;
        endcase
    end

    always_ff @(posedge MCLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state          <= S_IDLE;
            step           <= ST_REQ;
            cnt            <= '0;
            page_acc       <= 1'b0;
            buf_wr_n       <= 1'b1;
            buf_addr       <= '0;
            seq.cmd_start  <= 1'b0;
            seq.cs_release <= 1'b0;
            map.rewind     <= 1'b0;
        end
        else
        begin
            seq.cmd_start  <= 1'b0;
            seq.cs_release <= 1'b0;
            map.rewind     <= 1'b0;
            case (state)
                S_IDLE:
                    if (acc_req)
                    begin
                        state         <= S_CMD;
                        page_acc      <= acc_page;
                        seq.cmd_start <= 1'b1;
                        map.rewind    <= 1'b1;     // boot writes and page reads start at 0
                    end
                S_WAIT_REL:
                    if (!acc_req)
                        state <= S_IDLE;
                S_CMD:
                    if (seq.cmd_done)
                    begin
                        cnt <= '0;
                        if (page_acc)
                        begin
                            state    <= S_SYNC;
                            step     <= ST_MAPRD;
                            buf_addr <= bubble_pkg::page_base;
                        end
                        else
                        begin
                            state    <= S_BOOT;
                            step     <= ST_REQ;
                            buf_addr <= bubble_pkg::boot_base;
                        end
                    end
                default:
                    case (step)
                        ST_REQ:   step <= ST_WAIT;
                        ST_MAPRD: step <= ST_MAPCHK;
                        ST_WAIT, ST_MAPCHK:
                            if (wr_go)
                            begin
                                buf_wr_n <= 1'b0;
                                step     <= ST_WR;
                                cnt      <= cnt + bubble_pkg::bit_cnt_t'(good);
                            end
                            else if (step == ST_MAPCHK)
                            begin
                                step <= ST_REQ;    // good loop, page bit from flash
                            end
                        default:                   // ST_WR
                        begin
                            buf_wr_n <= 1'b1;
                            buf_addr <= buf_addr + 1'b1;
                            if (!last_bit)
                            begin
                                step <= (state inside {S_SYNC, S_PAGE}) ? ST_MAPRD : ST_REQ;
                            end
                            else if (state == S_BOOT)
                            begin
                                state <= S_MAP;    // map follows directly in flash
                                cnt   <= '0;
                                step  <= ST_REQ;
                            end
                            else if (state == S_SYNC)
                            begin
                                state <= S_PAGE;
                                cnt   <= '0;
                                step  <= ST_MAPRD;
                            end
                            else
                            begin
                                state          <= S_WAIT_REL;
                                step           <= ST_REQ;
                                seq.cs_release <= 1'b1;
                            end
                        end
                    endcase
            endcase
        end
    end

    // command word and buffer data
    always_ff @(posedge MCLK)
    begin
        if ((state == S_IDLE) && acc_req)
            seq.cmd <= flash_pkg::build_cmd(img_num, acc_page ? page_num : flash_pkg::boot_page);
        if (wr_go)
            buf_data <= wr_bit;
    end

endmodule

//--- hdl/spi_loader.sv
`timescale 1ns/1ps

// bubble memory emulator loader, flash -> bubble out buffer
module spi_loader #(
    parameter int BOOT_BITS = 2656,  // bootloader length in bits
    parameter int PAGE_BITS = 1030   // page length in bits
) (
    input  logic                  MCLK,
    input  logic                  rst_n,
    input  flash_pkg::img_t       img_num,
    input  bubble_pkg::page_t     page_num,
    input  logic                  acc_req,   // level, held until cs rises
    input  logic                  acc_page,  // 1 page, 0 boot
    output logic                  buf_wr_n,
    output bubble_pkg::buf_addr_t buf_addr,
    output logic                  buf_data,
    output logic                  flash_cs_n,
    output logic                  flash_sck,
    output logic                  flash_mosi,
    input  logic                  flash_miso
);

    flash_if u_flash_if ();
    map_if   u_map_if ();

    load_sequencer #(
        .BOOT_BITS (BOOT_BITS),
        .PAGE_BITS (PAGE_BITS)
    ) u_load_sequencer (
        .MCLK     (MCLK),
        .rst_n    (rst_n),
        .img_num  (img_num),
        .page_num (page_num),
        .acc_req  (acc_req),
        .acc_page (acc_page),
        .seq      (u_flash_if.seq),
        .map      (u_map_if.seq),
        .buf_wr_n (buf_wr_n),
        .buf_addr (buf_addr),
        .buf_data (buf_data)
    );

    flash_reader u_flash_reader (
        .MCLK       (MCLK),
        .rst_n      (rst_n),
        .spi        (u_flash_if.spi),
        .flash_cs_n (flash_cs_n),
        .flash_sck  (flash_sck),
        .flash_mosi (flash_mosi),
        .flash_miso (flash_miso)
    );

    loop_map_table u_loop_map_table (
        .MCLK  (MCLK),
        .rst_n (rst_n),
        .tbl   (u_map_if.lut)
    );

endmodule

//--- test/loader_checker.sv
`timescale 1ns/1ps

// reference model of the loader that compares flash command and buffer writes
module loader_checker #(
    parameter int BOOT_BITS = 2656,
    parameter int PAGE_BITS = 1030
) (
    input logic                  MCLK,
    input logic                  rst_n,
    input flash_pkg::img_t       img_num,
    input bubble_pkg::page_t     page_num,
    input logic                  acc_req,
    input logic                  acc_page,
    input logic                  buf_wr_n,
    input bubble_pkg::buf_addr_t buf_addr,
    input logic                  buf_data,
    input logic                  flash_cs_n,
    input logic                  flash_sck,
    input logic                  flash_mosi
);

    typedef enum logic [1:0] {M_IDLE, M_BUSY, M_DRAIN, M_WAIT_REL} mstate_t;

    mstate_t               mst = M_IDLE;
    logic                  exp_q [$];          // expected buf_data in write order
    logic                  map_tbl [4096];     // model of the loop map
    bubble_pkg::buf_addr_t exp_addr;
    logic [31:0]           exp_cmd;
    logic [31:0]           cmd_sh;
    logic                  exp_b;
    logic                  cs_seen;            // chip select went low in this load
    int                    cmd_cnt = 0;
    int                    errors  = 0;
    int                    checks  = 0;
    int                    loads   = 0;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // flash content by bit address (byte address * 8 + bit offset)
    function automatic logic flash_bit(input logic [31:0] bit_addr);
        logic [31:0] h;
        logic [31:0] off;
        h   = xorshift(xorshift(32'h5262 ^ (bit_addr * 32'h9e37_79b1)));
        off = bit_addr - {5'b0, 2'b00, bit_addr[24:22], flash_pkg::boot_page, 10'b0};
        if (off >= 32'(BOOT_BITS) && off < 32'(BOOT_BITS) + bubble_pkg::map_bits)
            return h[3:0] != 4'h0;             // about 1 in 16 map bits bad
        return h[7];
    endfunction

    task automatic note_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    // builds the expected write stream for the request on the ports now
    task automatic start_load();
        logic [23:0] addr;
        logic [31:0] base;
        logic        b;
        int          good;
        int          idx;
        addr    = {2'b00, img_num, acc_page ? page_num : flash_pkg::boot_page, 7'b000_0000};
        exp_cmd = {flash_pkg::read_opcode, addr};
        base    = {5'b0, addr, 3'b000};
        good    = 0;
        idx     = 0;
        cs_seen = 1'b0;
        exp_q.delete();
        if (!acc_page)
        begin
            exp_addr = bubble_pkg::boot_base;
            for (int i = 0; i < BOOT_BITS + bubble_pkg::map_bits; i++)
                exp_q.push_back(flash_bit(base + i));
            for (int i = 0; i < bubble_pkg::map_bits; i++)
                map_tbl[(i ^ 15) % 4096] = exp_q[BOOT_BITS + i]; // low nibble inverted
        end
        else
        begin
            exp_addr = bubble_pkg::page_base;
            for (int n = 0; n < 4096 && good < bubble_pkg::sync_bits + PAGE_BITS; n++)
            begin
                b   = map_tbl[idx];
                idx = (idx + 1) % 4096;
                if (b !== 1'b1)
                    exp_q.push_back(1'b0);     // bad loop
                else if (good < bubble_pkg::sync_bits)
                    exp_q.push_back(1'b1);     // sync position
                else
                    exp_q.push_back(flash_bit(base + good - bubble_pkg::sync_bits));
                if (b === 1'b1)
                    good++;
            end
        end
    endtask

    always @(posedge MCLK)
    begin
        if (rst_n)
        begin
            case (mst)
                M_IDLE, M_WAIT_REL:
                begin
                    if (!flash_cs_n || !flash_sck || !buf_wr_n)
                        note_error("flash or buffer strobe active between loads");
                    if (mst == M_WAIT_REL)
                    begin
                        if (!acc_req)
                            mst = M_IDLE;
                    end
                    else if (acc_req)
                    begin
                        start_load();
                        loads++;
                        mst = M_BUSY;
                    end
                end
                M_BUSY:
                begin
                    if (!flash_cs_n)
                        cs_seen = 1'b1;
                    if (!buf_wr_n)
                    begin
                        checks++;
                        exp_b = exp_q.pop_front();
                        if (buf_addr !== exp_addr || buf_data !== exp_b)
                            note_error($sformatf("write %h/%b, expected %h/%b",
                                buf_addr, buf_data, exp_addr, exp_b));
                        exp_addr++;
                        if (exp_q.size() == 0)
                            mst = M_DRAIN;     // cs rises one cycle later
                    end
                    else if (flash_cs_n && cs_seen)
                    begin
                        note_error($sformatf("load ended with %0d writes missing",
                            exp_q.size()));
                        mst = M_DRAIN;
                    end
                end
                default:
                begin
                    if (!buf_wr_n)
                        note_error("buffer write after the expected count");
                    if (flash_cs_n)
                        mst = acc_req ? M_WAIT_REL : M_IDLE;
                end
            endcase
        end
    end

    // command bits sampled on rising sck where mosi is stable
    always @(posedge flash_sck)
    begin
        if (!flash_cs_n && cmd_cnt < 32)
        begin
            cmd_sh = {cmd_sh[30:0], flash_mosi};
            cmd_cnt++;
            if (cmd_cnt == 32)
            begin
                checks++;
                if (cmd_sh !== exp_cmd)
                    note_error($sformatf("command %h, expected %h", cmd_sh, exp_cmd));
            end
        end
    end

    always @(posedge flash_cs_n)
        cmd_cnt = 0;

endmodule

//--- test/loader_sva.sv
`timescale 1ns/1ps

// strobe rules, bound once on the spi side and once on the buffer side
module loader_sva (
    input logic MCLK,
    input logic rst_n,
    input logic cs_n,
    input logic sck,
    input logic wr_n
);

    int fails = 0;  // failed assertion count

    a_wr_pulse: assert property (@(posedge MCLK) disable iff (!rst_n) !wr_n |=> wr_n)
    else
    begin
        fails++;
        $error("buffer write strobe low for more than one cycle");
    end

    a_sck_quiet: assert property (@(posedge MCLK) disable iff (!rst_n)
        cs_n && $past(cs_n) |-> $stable(sck))
    else
    begin
        fails++;
        $error("sck toggled with chip select high");
    end

    a_idle: assert property (@(posedge MCLK) $rose(rst_n) |-> cs_n && sck && wr_n)
    else
    begin
        fails++;
        $error("strobes not idle high after reset");
    end

endmodule

bind flash_reader loader_sva u_spi_sva (
    .MCLK  (MCLK),
    .rst_n (rst_n),
    .cs_n  (flash_cs_n),
    .sck   (flash_sck),
    .wr_n  (1'b1)
);

bind load_sequencer loader_sva u_buf_sva (
    .MCLK  (MCLK),
    .rst_n (rst_n),
    .cs_n  (1'b1),
    .sck   (1'b1),
    .wr_n  (buf_wr_n)
);

//--- test/tb_spi_loader.sv
`timescale 1ns/1ps

module tb_spi_loader;

    localparam int BOOT_BITS = 2656;
    localparam int PAGE_BITS = 1030;
    localparam int ROWS      = 7;

    // {img_num, acc_page, page_num}
    localparam logic [15:0] stim [ROWS] = '{
        {3'd1, 1'b0, 12'h000},   // boot, loads map of image 1
        {3'd1, 1'b1, 12'h012},
        {3'd1, 1'b1, 12'h3a0},
        {3'd5, 1'b1, 12'h0c4},
        {3'd1, 1'b1, 12'hfff},
        {3'd6, 1'b0, 12'h000},   // second boot, new map
        {3'd6, 1'b1, 12'h200}
    };

    logic                  MCLK;
    logic                  rst_n;
    flash_pkg::img_t       img_num;
    bubble_pkg::page_t     page_num;
    logic                  acc_req;
    logic                  acc_page;
    logic                  buf_wr_n;
    bubble_pkg::buf_addr_t buf_addr;
    logic                  buf_data;
    logic                  flash_cs_n;
    logic                  flash_sck;
    logic                  flash_mosi;
    logic                  flash_miso;
    logic [31:0]           resp_cmd;      // command seen by the flash model
    int                    resp_cnt = 0;
    int                    resp_off = 0;
    int                    cycles   = 0;
    int                    limit;
    int                    total_err;

    spi_loader #(
        .BOOT_BITS (BOOT_BITS),
        .PAGE_BITS (PAGE_BITS)
    ) u_spi_loader (.*);

    loader_checker #(
        .BOOT_BITS (BOOT_BITS),
        .PAGE_BITS (PAGE_BITS)
    ) u_checker (.*);

    // page bits also need the map read, hence the larger factor
    function automatic int row_budget(input logic page_acc);
        if (page_acc)
            return 8 * (bubble_pkg::sync_bits + PAGE_BITS) + 200;
        return 4 * (BOOT_BITS + bubble_pkg::map_bits) + 200;
    endfunction

    initial
    begin
        MCLK = 1'b0;
        forever #5 MCLK = ~MCLK;
    end

    // flash model: 32 command bits in on rising sck, data out on falling sck
    always @(posedge flash_cs_n)
    begin
        resp_cnt = 0;
        resp_off = 0;
    end

    always @(posedge flash_sck)
    begin
        if (!flash_cs_n && resp_cnt < 32)
        begin
            resp_cmd = {resp_cmd[30:0], flash_mosi};
            resp_cnt++;
        end
    end

    always @(negedge flash_sck)
    begin
        if (!flash_cs_n && resp_cnt == 32)
        begin
            flash_miso = u_checker.flash_bit({5'b0, resp_cmd[23:0], 3'b000} + resp_off);
            resp_off++;
        end
    end

    always @(posedge MCLK)
    begin
        cycles++;
        if (cycles > limit)
        begin
            $display("Run stopped after %0d cycles with the table unfinished", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial
    begin
        rst_n      = 1'b0;
        acc_req    = 1'b0;
        acc_page   = 1'b0;
        img_num    = '0;
        page_num   = '0;
        flash_miso = 1'b0;
        limit      = 40;
        for (int r = 0; r < ROWS; r++)
            limit += row_budget(stim[r][12]);
        repeat (10) @(negedge MCLK);
        rst_n = 1'b1;
        repeat (3) @(negedge MCLK);
        for (int r = 0; r < ROWS; r++)
        begin
            {img_num, acc_page, page_num} = stim[r];
            acc_req = 1'b1;
            @(negedge flash_cs_n);
            @(posedge flash_cs_n);           // load done
            repeat (5) @(negedge MCLK);      // request still high, no restart allowed
            acc_req = 1'b0;
            repeat (4) @(negedge MCLK);
        end
        total_err = u_checker.errors + u_spi_loader.u_flash_reader.u_spi_sva.fails
                  + u_spi_loader.u_load_sequencer.u_buf_sva.fails;
        $display("loads %0d, checks %0d, errors %0d", u_checker.loads, u_checker.checks,
            total_err);
        if (total_err == 0 && u_checker.loads == ROWS)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- vlog.f
common/flash_pkg.sv
common/bubble_pkg.sv
common/flash_if.sv
common/map_if.sv
flash/flash_reader.sv
hdl/loop_map_table.sv
hdl/load_sequencer.sv
hdl/spi_loader.sv
test/loader_checker.sv
test/loader_sva.sv
test/tb_spi_loader.sv
